//--- all.f
+incdir+src
src/timer_bus_pkg.sv
src/timer_pkg.sv
src/timer_ctrl_if.sv
src/timer_core.sv
src/timer_regs.sv
src/timer.sv
testbench/tb_timer.sv

//--- testbench/tb_timer.sv
//----------------------------------------
// Timer testbench, LFSR stimulus with seed 60
// Reads sampled at the falling edge, every wait bounded
//----------------------------------------
`timescale 1ns/1ps
`include "timer_macros.svh"

module tb_timer;

  localparam timer_bus_pkg::data_t START_CMD = 32'd1 << `TIMER_CTRL_START_BIT;
  localparam timer_bus_pkg::data_t STOP_CMD  = 32'd1 << `TIMER_CTRL_STOP_BIT;
  localparam int WAIT_LIMIT = 300;

  logic                 clk;
  logic                 reset_n;
  logic                 cs;
  logic                 we;
  timer_bus_pkg::addr_t address;
  timer_bus_pkg::data_t write_data;
  timer_bus_pkg::data_t read_data;
  logic                 ready;

  // Random source and counters
  logic [31:0] lfsr;
  int errors;
  int test_errors;
  int tests_passed;
  int tests_failed;

  // Model state, updated at each rising edge
  timer_pkg::timer_cfg_t m_cfg;
  timer_pkg::count_t     m_count;
  timer_pkg::count_t     m_presc;
  logic                  m_running;
  logic                  m_start;
  logic                  m_stop;

  timer dut_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .ready      (ready)
  );

  always #10 clk = ~clk;

  //----------------------------------------
  // Cycle model
  //----------------------------------------
  always @(posedge clk) begin : model
    timer_pkg::count_t period;
    logic tick;
    logic load;
    logic locked;
    logic ctrl_wr;
    if (!reset_n) begin
      m_cfg     = '0;
      m_count   = '0;
      m_presc   = '0;
      m_running = 1'b0;
      m_start   = 1'b0;
      m_stop    = 1'b0;
    end else begin
      // Prescaler 0 behaves as 1
      period = (m_cfg.prescaler == '0) ? 32'd1 : m_cfg.prescaler;
      tick   = m_running && (m_presc == period - 32'd1);
      load   = m_start && !m_running && (m_cfg.free_running || m_cfg.timer_init != '0);
      locked = m_running;
      if (load) begin
        m_running = 1'b1;
        m_count   = m_cfg.timer_init;
        m_presc   = '0;
      end else if (m_stop) begin
        m_running = 1'b0;
      end else if (tick) begin
        // One-shot ends when the count reaches zero
        if (!m_cfg.free_running && m_count == 32'd1) m_running = 1'b0;
        m_count = m_count - 32'd1;
        m_presc = '0;
      end else if (m_running) begin
        m_presc = m_presc + 32'd1;
      end
      // Config writes only while idle
      if (cs && we && !locked) begin
        case (address)
          `TIMER_ADDR_PRESCALER:    m_cfg.prescaler = write_data;
          `TIMER_ADDR_TIMER:        m_cfg.timer_init = write_data;
          `TIMER_ADDR_FREE_RUNNING: m_cfg.free_running = write_data[`TIMER_FREE_RUNNING_BIT];
          default: ;
        endcase
      end
      // Strobes for the next cycle, stop wins
      ctrl_wr = cs && we && (address == `TIMER_ADDR_CTRL);
      m_stop  = ctrl_wr && write_data[`TIMER_CTRL_STOP_BIT];
      m_start = ctrl_wr && write_data[`TIMER_CTRL_START_BIT] && !m_stop;
    end
  end

  // Read value the register map gives for the model state
  function automatic timer_bus_pkg::data_t expected_read(input timer_bus_pkg::addr_t addr);
    expected_read = '0;
    case (addr)
      `TIMER_ADDR_STATUS:       expected_read[`TIMER_STATUS_RUNNING_BIT] = m_running;
      `TIMER_ADDR_PRESCALER:    expected_read = m_cfg.prescaler;
      `TIMER_ADDR_TIMER:        expected_read = m_running ? m_count : m_cfg.timer_init;
      `TIMER_ADDR_FREE_RUNNING: expected_read[`TIMER_FREE_RUNNING_BIT] = m_cfg.free_running;
      default: ;
    endcase
  endfunction

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  //----------------------------------------
  // Compare and bus tasks
  //----------------------------------------
  task automatic check_data(input string name, input timer_bus_pkg::data_t exp,
                            input timer_bus_pkg::data_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_running(input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR running expected %h actual %h", exp, act);
      errors++;
    end
  endtask

  // One access cycle, entered and left 1 ns after a rising edge
  task automatic access(input logic wr, input timer_bus_pkg::addr_t addr,
                        input timer_bus_pkg::data_t data,
                        output timer_bus_pkg::data_t rd, output timer_bus_pkg::data_t exp);
    cs         = 1'b1;
    we         = wr;
    address    = addr;
    write_data = data;
    @(negedge clk);
    rd  = read_data;
    exp = expected_read(addr);
    check_data("ready", 32'd1, {31'b0, ready});
    @(posedge clk);
    #1;
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic write_reg(input timer_bus_pkg::addr_t addr, input timer_bus_pkg::data_t data);
    timer_bus_pkg::data_t rd;
    timer_bus_pkg::data_t exp;
    access(1'b1, addr, data, rd, exp);
  endtask

  task automatic read_expect(input timer_bus_pkg::addr_t addr, input string name);
    timer_bus_pkg::data_t rd;
    timer_bus_pkg::data_t exp;
    access(1'b0, addr, '0, rd, exp);
    check_data(name, exp, rd);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Poll status until running falls, count the cycles it was high
  task automatic wait_idle(output int high_cycles);
    timer_bus_pkg::data_t rd;
    timer_bus_pkg::data_t exp;
    int i;
    high_cycles = 0;
    for (i = 0; i < WAIT_LIMIT; i++) begin
      access(1'b0, `TIMER_ADDR_STATUS, '0, rd, exp);
      check_running(exp[`TIMER_STATUS_RUNNING_BIT], rd[`TIMER_STATUS_RUNNING_BIT]);
      if (rd[`TIMER_STATUS_RUNNING_BIT]) high_cycles++;
      else if (i > 0) break;
    end
    if (i == WAIT_LIMIT) begin
      $display("Timeout: running did not fall within %0d cycles", WAIT_LIMIT);
      errors++;
    end
  endtask

  // Read the timer register n cycles in a row
  task automatic watch_count(input int n, output logic saw_wrap);
    timer_bus_pkg::data_t rd;
    timer_bus_pkg::data_t exp;
    saw_wrap = 1'b0;
    repeat (n) begin
      access(1'b0, `TIMER_ADDR_TIMER, '0, rd, exp);
      check_data("curr_timer", exp, rd);
      if (rd == '1) saw_wrap = 1'b1;
    end
  endtask

  // Stop strobe next cycle, running low the cycle after
  task automatic stop_and_check();
    timer_bus_pkg::data_t rd;
    timer_bus_pkg::data_t exp;
    write_reg(`TIMER_ADDR_CTRL, STOP_CMD);
    access(1'b0, `TIMER_ADDR_STATUS, '0, rd, exp);
    check_running(1'b1, rd[`TIMER_STATUS_RUNNING_BIT]);
    access(1'b0, `TIMER_ADDR_STATUS, '0, rd, exp);
    check_running(1'b0, rd[`TIMER_STATUS_RUNNING_BIT]);
  endtask

  task automatic end_test(input string name);
    if (errors == test_errors) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - test_errors);
      tests_failed++;
    end
    test_errors = errors;
  endtask

  //----------------------------------------
  // Test sequence
  //----------------------------------------
  initial begin
    timer_bus_pkg::data_t rd;
    timer_bus_pkg::data_t exp;
    timer_bus_pkg::addr_t addr;
    timer_pkg::count_t    presc;
    timer_pkg::count_t    init;
    int                   cycles;
    logic                 wrapped;
    clk          = 1'b0;
    reset_n      = 1'b0;
    cs           = 1'b0;
    we           = 1'b0;
    address      = '0;
    write_data   = '0;
    lfsr         = 32'd60;
    errors       = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk);
    #1;
    reset_n = 1'b1;

    // Status through mode read 0, ready low while idle
    for (int a = `TIMER_ADDR_STATUS; a <= `TIMER_ADDR_FREE_RUNNING; a++) begin
      access(1'b0, timer_bus_pkg::addr_t'(a), '0, rd, exp);
      check_data("read_data", '0, rd);
    end
    @(negedge clk);
    check_data("ready", '0, {31'b0, ready});
    @(posedge clk);
    #1;
    end_test("reset state");

    repeat (4) begin
      write_reg(`TIMER_ADDR_PRESCALER, rand_bits(32));
      write_reg(`TIMER_ADDR_TIMER, rand_bits(32));
      write_reg(`TIMER_ADDR_FREE_RUNNING, rand_bits(32));
      read_expect(`TIMER_ADDR_PRESCALER, "prescaler");
      read_expect(`TIMER_ADDR_TIMER, "timer_init");
      read_expect(`TIMER_ADDR_FREE_RUNNING, "free_running");
      // Keep clear of the mapped range
      addr = timer_bus_pkg::addr_t'(rand_bits(8));
      if (addr inside {[`TIMER_ADDR_CTRL:`TIMER_ADDR_FREE_RUNNING]}) addr = addr + 8'h10;
      access(1'b0, addr, '0, rd, exp);
      check_data("read_data", '0, rd);
    end
    end_test("idle readback");

    write_reg(`TIMER_ADDR_FREE_RUNNING, '0);
    repeat (2) begin
      presc = rand_bits(2);
      init  = rand_bits(3) + 32'd1;
      write_reg(`TIMER_ADDR_PRESCALER, presc);
      write_reg(`TIMER_ADDR_TIMER, init);
      write_reg(`TIMER_ADDR_CTRL, START_CMD);
      wait_idle(cycles);
      check_data("run_cycles", init * ((presc == '0) ? 32'd1 : presc), cycles);
      // Second run, watch the live count
      write_reg(`TIMER_ADDR_CTRL, START_CMD);
      watch_count(4, wrapped);
      wait_idle(cycles);
    end
    end_test("one-shot run");

    write_reg(`TIMER_ADDR_PRESCALER, 32'd2);
    write_reg(`TIMER_ADDR_TIMER, 32'd20);
    write_reg(`TIMER_ADDR_CTRL, START_CMD);
    read_expect(`TIMER_ADDR_STATUS, "status");
    write_reg(`TIMER_ADDR_PRESCALER, rand_bits(32));
    write_reg(`TIMER_ADDR_TIMER, rand_bits(32));
    // Mode bit always set, so a leaked write shows
    write_reg(`TIMER_ADDR_FREE_RUNNING, rand_bits(32) | (32'd1 << `TIMER_FREE_RUNNING_BIT));
    access(1'b0, `TIMER_ADDR_PRESCALER, '0, rd, exp);
    check_data("prescaler", 32'd2, rd);
    read_expect(`TIMER_ADDR_FREE_RUNNING, "free_running");
    write_reg(`TIMER_ADDR_CTRL, START_CMD);
    read_expect(`TIMER_ADDR_STATUS, "status");
    read_expect(`TIMER_ADDR_TIMER, "curr_timer");
    wait_idle(cycles);
    // Init value survives the write during the run
    access(1'b0, `TIMER_ADDR_TIMER, '0, rd, exp);
    check_data("timer_init", 32'd20, rd);
    // One-shot from zero must not start
    write_reg(`TIMER_ADDR_TIMER, '0);
    write_reg(`TIMER_ADDR_CTRL, START_CMD);
    repeat (2) begin
      access(1'b0, `TIMER_ADDR_STATUS, '0, rd, exp);
      check_running(1'b0, rd[`TIMER_STATUS_RUNNING_BIT]);
    end
    end_test("write protection");

    write_reg(`TIMER_ADDR_PRESCALER, 32'd1);
    write_reg(`TIMER_ADDR_TIMER, 32'd50);
    write_reg(`TIMER_ADDR_CTRL, START_CMD);
    idle(rand_bits(3));
    stop_and_check();
    init = rand_bits(2) + 32'd1;
    write_reg(`TIMER_ADDR_TIMER, init);
    write_reg(`TIMER_ADDR_FREE_RUNNING, 32'd1);
    write_reg(`TIMER_ADDR_CTRL, START_CMD);
    watch_count(init + 4, wrapped);
    if (!wrapped) begin
      $display("Free-running count never wrapped to ffffffff");
      errors++;
    end
    idle(20);
    read_expect(`TIMER_ADDR_TIMER, "curr_timer");
    stop_and_check();
    end_test("stop and free-running");

    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- src/timer.sv
//----------------------------------------
// Timer top, single-cycle cs/we bus
// No interrupt, poll the status register
//----------------------------------------
`timescale 1ns/1ps

module timer (
  input  logic                 clk,
  input  logic                 reset_n,

  // Register bus
  input  logic                 cs,
  input  logic                 we,
  input  timer_bus_pkg::addr_t address,
  input  timer_bus_pkg::data_t write_data,
  output timer_bus_pkg::data_t read_data,
  output logic                 ready
);

  // Front end to core link
  timer_ctrl_if ctrl_if ();

  //----------------------------------------
  // Register front end
  //----------------------------------------
  timer_regs regs_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .ready      (ready),
    .ctrl       (ctrl_if.regs)
  );

  //----------------------------------------
  // Counter core
  //----------------------------------------
  timer_core core_i (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl    (ctrl_if.core)
  );

endmodule

//--- src/timer_regs.sv
//----------------------------------------
// Register front end, zero wait states
// Config writes are dropped while running
//----------------------------------------
`timescale 1ns/1ps
`include "timer_macros.svh"

module timer_regs (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 cs,
  input  logic                 we,
  input  timer_bus_pkg::addr_t address,
  input  timer_bus_pkg::data_t write_data,
  output timer_bus_pkg::data_t read_data,
  output logic                 ready,
  timer_ctrl_if.regs           ctrl
);

  //----------------------------------------
  // Declarations
  //----------------------------------------
  timer_bus_pkg::reg_idx_t reg_idx;
  timer_pkg::timer_cfg_t   cfg_reg;

  logic start_reg;
  logic stop_reg;

  logic wr_en;
  logic rd_en;
  logic cfg_wr;
  logic ctrl_wr;
  logic start_new;
  logic stop_new;

  // Map a bus address onto a register
  function automatic timer_bus_pkg::reg_idx_t decode(input timer_bus_pkg::addr_t addr);
    case (addr)
      `TIMER_ADDR_CTRL:         decode = timer_bus_pkg::REG_CTRL;
      `TIMER_ADDR_STATUS:       decode = timer_bus_pkg::REG_STATUS;
      `TIMER_ADDR_PRESCALER:    decode = timer_bus_pkg::REG_PRESCALER;
      `TIMER_ADDR_TIMER:        decode = timer_bus_pkg::REG_TIMER;
      `TIMER_ADDR_FREE_RUNNING: decode = timer_bus_pkg::REG_FREE_RUNNING;
      default:                  decode = timer_bus_pkg::REG_NONE;
    endcase
  endfunction

  //----------------------------------------
  // Bus decode
  //----------------------------------------
  // Every access completes in its own cycle
  assign ready   = cs;
  assign wr_en   = cs && we;
  assign rd_en   = cs && !we;
  assign reg_idx = decode(address);

  // Config locked while the core runs
  assign cfg_wr  = wr_en && !ctrl.running;
  assign ctrl_wr = wr_en && (reg_idx == timer_bus_pkg::REG_CTRL);

  // Stop has priority over start
  assign stop_new  = ctrl_wr && write_data[`TIMER_CTRL_STOP_BIT];
  assign start_new = ctrl_wr && write_data[`TIMER_CTRL_START_BIT] && !stop_new;

  //----------------------------------------
  // Registers
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      start_reg <= 1'b0;
      stop_reg  <= 1'b0;
    end else begin
      // One-cycle strobes, the cycle after the write
      start_reg <= start_new;
      stop_reg  <= stop_new;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      cfg_reg <= timer_pkg::CFG_RESET;
    end else if (cfg_wr) begin
      case (reg_idx)
        timer_bus_pkg::REG_PRESCALER:    cfg_reg.prescaler  <= write_data;
        timer_bus_pkg::REG_TIMER:        cfg_reg.timer_init <= write_data;
        timer_bus_pkg::REG_FREE_RUNNING: begin
          cfg_reg.free_running <= write_data[`TIMER_FREE_RUNNING_BIT];
        end
        // Status and unmapped addresses take no write
        default: ;
      endcase
    end
  end

  assign ctrl.cfg   = cfg_reg;
  assign ctrl.start = start_reg;
  assign ctrl.stop  = stop_reg;

  //----------------------------------------
  // Read multiplexer
  //----------------------------------------
  always_comb begin
    read_data = '0;
    if (rd_en) begin
      case (reg_idx)
        timer_bus_pkg::REG_STATUS: begin
          read_data[`TIMER_STATUS_RUNNING_BIT] = ctrl.running;
        end
        timer_bus_pkg::REG_PRESCALER: read_data = cfg_reg.prescaler;
        timer_bus_pkg::REG_TIMER: begin
          // Live count while running, init value when idle
          read_data = ctrl.running ? ctrl.curr_timer : cfg_reg.timer_init;
        end
        timer_bus_pkg::REG_FREE_RUNNING: begin
          read_data[`TIMER_FREE_RUNNING_BIT] = cfg_reg.free_running;
        end
        // Control is write-only, unmapped reads 0
        default: read_data = '0;
      endcase
    end
  end

  //----------------------------------------
  // Assertions
  //----------------------------------------
  // Strobes are exclusive
  a_strobes_exclusive: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(start_reg && stop_reg)
  );

  // Bus never stalls
  a_ready_is_cs: assert property (
    @(posedge clk) disable iff (!reset_n)
    ready == cs
  );

endmodule

//--- src/timer_core.sv
//----------------------------------------
// Prescaler and countdown, runs on clk only
// Config must stay stable while running
//----------------------------------------
`timescale 1ns/1ps

module timer_core (
  input logic        clk,
  input logic        reset_n,
  timer_ctrl_if.core ctrl
);

  //----------------------------------------
  // Declarations
  //----------------------------------------
  // Cycles since the last tick or load
  timer_pkg::count_t presc_cnt;
  // Count value that ends a prescaler period
  timer_pkg::count_t presc_last;

  timer_pkg::count_t curr_timer_reg;
  logic              running_reg;

  logic start_ok;
  logic load;
  logic tick;
  logic last_tick;

  //----------------------------------------
  // Control decode
  //----------------------------------------
  // Prescaler of 0 ticks every cycle like 1
  assign presc_last = (ctrl.cfg.prescaler == '0) ?
                      '0 : ctrl.cfg.prescaler - timer_pkg::count_t'(1);

  // One-shot from zero would never end, so refuse it
  assign start_ok = ctrl.cfg.free_running || (ctrl.cfg.timer_init != '0);

  // Start while running is ignored, stop wins
  assign load = ctrl.start && !ctrl.stop && !running_reg && start_ok;

  // One tick per prescaler period
  assign tick = running_reg && (presc_cnt == presc_last);

  // Tick that brings a one-shot count to zero
  assign last_tick = tick && !ctrl.cfg.free_running &&
                     (curr_timer_reg == timer_pkg::count_t'(1));

  //----------------------------------------
  // Prescaler
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      presc_cnt <= '0;
    end else if (load || tick) begin
      // New period starts at load and after each tick
      presc_cnt <= '0;
    end else if (running_reg) begin
      presc_cnt <= presc_cnt + timer_pkg::count_t'(1);
    end
  end

  //----------------------------------------
  // Countdown and running flag
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      running_reg    <= 1'b0;
      curr_timer_reg <= '0;
    end else if (load) begin
      running_reg    <= 1'b1;
      curr_timer_reg <= ctrl.cfg.timer_init;
    end else if (ctrl.stop) begin
      // Count is held, idle readback shows the init value
      running_reg <= 1'b0;
    end else if (tick) begin
      // Free-running wraps from 0 to all ones
      curr_timer_reg <= curr_timer_reg - timer_pkg::count_t'(1);
      if (last_tick) begin
        running_reg <= 1'b0;
      end
    end
  end

  assign ctrl.running    = running_reg;
  assign ctrl.curr_timer = curr_timer_reg;

  //----------------------------------------
  // Assertions
  //----------------------------------------
  // Running only rises one cycle after a start strobe
  a_running_needs_start: assert property (
    @(posedge clk) disable iff (!reset_n)
    $rose(running_reg) |-> $past(ctrl.start)
  );

  // Count moves only on a tick or a load
  a_count_changes: assert property (
    @(posedge clk) disable iff (!reset_n)
    $changed(curr_timer_reg) |-> $past(tick || load)
  );

endmodule

//--- src/timer_ctrl_if.sv
//----------------------------------------
// Link between register front end and core
// start and stop are one-cycle strobes, no ack
//----------------------------------------
`timescale 1ns/1ps

interface timer_ctrl_if;

  // Configuration from the register file
  timer_pkg::timer_cfg_t cfg;

  // Command strobes, never both high
  logic start;
  logic stop;

  // Core state back to the registers
  timer_pkg::count_t curr_timer;
  logic              running;

  // Register side
  modport regs (
    output cfg, start, stop,
    input  curr_timer, running
  );

  // Core side
  modport core (
    input  cfg, start, stop,
    output curr_timer, running
  );

endinterface

//--- src/timer_pkg.sv
//----------------------------------------
// Timer configuration and count types
// Count width follows the bus data width
//----------------------------------------
`include "timer_macros.svh"

package timer_pkg;

  // Prescaler or timer value
  typedef logic [`TIMER_DATA_W-1:0] count_t;

  // Full configuration, 65 bits
  // Stable while the timer runs
  typedef struct packed {
    // Cycles per tick, 0 acts as 1
    count_t prescaler;
    // Loaded into the counter at start
    count_t timer_init;
    // Wrap past zero instead of stopping
    logic   free_running;
  } timer_cfg_t;

  // Reset value of the configuration
  localparam timer_cfg_t CFG_RESET = '{
    prescaler:    '0,
    timer_init:   '0,
    free_running: 1'b0
  };

endpackage

//--- src/timer_bus_pkg.sv
//----------------------------------------
// Register bus types, widths from timer_macros.svh
//----------------------------------------
`include "timer_macros.svh"

package timer_bus_pkg;

  // Bus address and data word
  typedef logic [`TIMER_ADDR_W-1:0] addr_t;
  typedef logic [`TIMER_DATA_W-1:0] data_t;

  // Decoded register, REG_NONE for unmapped addresses
  typedef enum logic [2:0] {
    REG_CTRL,
    REG_STATUS,
    REG_PRESCALER,
    REG_TIMER,
    REG_FREE_RUNNING,
    REG_NONE
  } reg_idx_t;

endpackage

//--- src/timer_macros.svh
//----------------------------------------
// Register map and bit positions of the timer
// Addresses assume the 8-bit bus address width
//----------------------------------------
`ifndef TIMER_MACROS_SVH
`define TIMER_MACROS_SVH

// Bus widths
`define TIMER_ADDR_W 8
`define TIMER_DATA_W 32

// Register addresses
`define TIMER_ADDR_CTRL         8'h08
`define TIMER_ADDR_STATUS       8'h09
`define TIMER_ADDR_PRESCALER    8'h0a
`define TIMER_ADDR_TIMER        8'h0b
`define TIMER_ADDR_FREE_RUNNING 8'h0c

// Bit positions inside the register words
`define TIMER_CTRL_START_BIT     0
`define TIMER_CTRL_STOP_BIT      1
`define TIMER_STATUS_RUNNING_BIT 0
`define TIMER_FREE_RUNNING_BIT   0

`endif
